//--- hw/fetch_pkg.sv
package fetch_pkg;

    localparam int XLEN = 32;                       // Bus address and data width

    // Transfer types driven by the fetch master
    localparam logic [1:0] HTRANS_IDLE   = 2'b00;   // No transfer
    localparam logic [1:0] HTRANS_NONSEQ = 2'b10;   // Single word fetch

    // Outcome of one fetch as delivered to decode
    typedef enum logic [1:0] {
        FETCH_VALID = 2'b00,                        // Instruction fetched normally
        FETCH_BSERR = 2'b01,                        // Slave answered with an error
        FETCH_PMAVN = 2'b10                         // Address not executable
    } fetch_status_e;

    // Master to slave, only the fields the fetch stage drives
    typedef struct packed {
        logic [XLEN-1:0] haddr;                     // Always word aligned
        logic [1:0]      htrans;                    // IDLE or NONSEQ
    } ahb_req_t;

    // Slave to master
    typedef struct packed {
        logic [XLEN-1:0] hrdata;
        logic            hready;                    // Phase completes when high
        logic            hresp;                     // Error, valid with hready
    } ahb_rsp_t;

    // One slot of the instruction fetch buffer, 66 bits
    typedef struct packed {
        logic [XLEN-1:0] instr;                     // Zero for a PMA fault
        logic [XLEN-1:0] addr;                      // Fetch address of instr
        fetch_status_e   status;
    } ifb_entry_t;

endpackage

//--- hw/fetch_cfg_pkg.sv
package fetch_cfg_pkg;

    // Register bus request, one access per setup and access phase
    typedef struct packed {
        logic                        psel;
        logic                        penable;
        logic                        pwrite;
        logic [11:0]                 paddr;         // Byte offset inside the block
        logic [fetch_pkg::XLEN-1:0]  pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [fetch_pkg::XLEN-1:0]  prdata;
        logic                        pready;        // Tied high, no wait states
        logic                        pslverr;       // Unmapped offset
    } apb_rsp_t;

    // Register map
    localparam logic [11:0] REG_CTRL   = 12'h000;   // Bit 0 fetch enable
    localparam logic [11:0] REG_ATTR   = 12'h004;   // Bit k exec of region k
    localparam logic [11:0] REG_BASE0  = 12'h010;   // Base of region 0
    localparam logic [11:0] REG_MASK0  = 12'h014;   // Mask of region 0
    localparam logic [11:0] REG_STRIDE = 12'h008;   // Distance between regions

    // One entry of the executable memory table
    // Address hits the region when (addr & mask) == base
    typedef struct packed {
        logic [fetch_pkg::XLEN-1:0]  base;
        logic [fetch_pkg::XLEN-1:0]  mask;
        logic                        exec;          // Region may be fetched from
    } pma_region_t;

endpackage

//--- hw/fetch_cfg_regs.sv
module fetch_cfg_regs import fetch_pkg::*, fetch_cfg_pkg::*; #(
    parameter int PMA_REGIONS = 2
) (
    input  logic        s_clk_i,
    input  logic        arst_n_i,
    input  apb_req_t    apb_req_i,                  // Register bus request
    output apb_rsp_t    apb_rsp_o,                  // Register bus response
    output logic        fetch_en_o,                 // Fetch may issue transfers
    output pma_region_t regions_o [PMA_REGIONS]     // Region table for the PMA check
);

    logic                   fetch_en_q;
    pma_region_t            regions_q [PMA_REGIONS];

    logic                   access;                 // Access phase of a transfer
    logic                   wr_en;
    logic                   hit_ctrl;
    logic                   hit_attr;
    logic [PMA_REGIONS-1:0] hit_base;
    logic [PMA_REGIONS-1:0] hit_mask;
    logic                   mapped;                 // Offset belongs to the map
    logic [XLEN-1:0]        rd_data;

    assign access = apb_req_i.psel & apb_req_i.penable;
    assign wr_en  = access & apb_req_i.pwrite;

    // Offset decode and read mux
    always_comb begin
        hit_ctrl = (apb_req_i.paddr == REG_CTRL);
        hit_attr = (apb_req_i.paddr == REG_ATTR);
        rd_data  = '0;
        if (hit_ctrl)
            rd_data[0] = fetch_en_q;
        for (int k = 0; k < PMA_REGIONS; k++) begin
            hit_base[k] = (apb_req_i.paddr == REG_BASE0 + 12'(REG_STRIDE * k));
            hit_mask[k] = (apb_req_i.paddr == REG_MASK0 + 12'(REG_STRIDE * k));
            if (hit_attr)
                rd_data[k] = regions_q[k].exec;     // Exec bits gathered into ATTR
            if (hit_base[k])
                rd_data = regions_q[k].base;
            if (hit_mask[k])
                rd_data = regions_q[k].mask;
        end
    end

    assign mapped = hit_ctrl | hit_attr | (|hit_base) | (|hit_mask);

    // Response is combinational in the access phase
    assign apb_rsp_o.prdata  = (access & mapped) ? rd_data : '0;
    assign apb_rsp_o.pready  = 1'b1;
    assign apb_rsp_o.pslverr = access & ~mapped;

    // Writes land at the edge closing the access
    always_ff @(posedge s_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            fetch_en_q <= 1'b0;
            for (int k = 0; k < PMA_REGIONS; k++)
                regions_q[k] <= '0;                 // Mask zero, nothing executable
        end else if (wr_en) begin
            if (hit_ctrl)
                fetch_en_q <= apb_req_i.pwdata[0];
            for (int k = 0; k < PMA_REGIONS; k++) begin
                if (hit_attr)
                    regions_q[k].exec <= apb_req_i.pwdata[k];
                if (hit_base[k])
                    regions_q[k].base <= apb_req_i.pwdata;
                if (hit_mask[k])
                    regions_q[k].mask <= apb_req_i.pwdata;
            end
        end
    end

    assign fetch_en_o = fetch_en_q;
    assign regions_o  = regions_q;

endmodule

//--- hw/fetch_pma.sv
module fetch_pma import fetch_pkg::*, fetch_cfg_pkg::*; #(
    parameter int PMA_REGIONS = 2
) (
    input  logic [XLEN-1:0] addr_i,                 // Address held in FE0
    input  pma_region_t     regions_i [PMA_REGIONS],
    output logic            exec_ok_o               // Some exec region covers addr_i
);

    logic [PMA_REGIONS-1:0] region_hit;

    // One masked compare per region
    always_comb begin
        for (int k = 0; k < PMA_REGIONS; k++) begin
            region_hit[k] = regions_i[k].exec &
                            ((addr_i & regions_i[k].mask) == regions_i[k].base);
        end
    end

    // Any executable hit is enough
    // A cleared table (mask zero, exec low) blocks every address
    assign exec_ok_o = |region_hit;

endmodule

//--- hw/fetch_addr_phase.sv
module fetch_addr_phase import fetch_pkg::*; #(
    parameter int IFB_DEPTH = 4
) (
    input  logic                           s_clk_i,
    input  logic                           arst_n_i,
    input  logic                           fetch_en_i,      // Fetch enable from CTRL
    input  logic                           redirect_i,      // Later stage changes flow
    input  logic [XLEN-1:0]                redirect_addr_i, // New fetch target
    input  logic                           exec_ok_i,       // PMA result for FE0
    input  logic [$clog2(IFB_DEPTH+1)-1:0] ifb_free_i,      // Free IFB slots
    input  ahb_rsp_t                       ahb_rsp_i,
    output ahb_req_t                       ahb_req_o,
    output logic [XLEN-1:0]                fe0_addr_o,      // Address under PMA check
    output logic                           ifb_push_o,
    output ifb_entry_t                     ifb_wdata_o,
    output logic                           flush_o          // Clears the IFB
);

    localparam int CNT_W = $clog2(IFB_DEPTH + 1);

    // FE1 info codes
    localparam logic [1:0] INF_NONE   = 2'b00;
    localparam logic [1:0] INF_PMAVN  = 2'b01;              // Blocked fetch, no transfer
    localparam logic [1:0] INF_PARKED = 2'b10;              // Target waits for FE0

    logic [XLEN-1:0] fe0_add_q, fe0_add_d;
    logic            fe0_utd_q, fe0_utd_d;
    logic [XLEN-1:0] fe1_add_q, fe1_add_d;
    logic            fe1_utd_q, fe1_utd_d;
    logic [1:0]      fe1_inf_q, fe1_inf_d;
    logic            halt_q, halt_d;                        // Stopped after a PMA fault

    logic            fe0_live;                              // FE0 takes part on the bus
    logic            pma_viol;
    logic            stuck;                                 // Address phase held by wait
    logic            parked;
    logic            fe1_pmavn;
    logic [1:0]      inflight;                              // Up-to-date phases
    logic            ifb_room;
    logic [XLEN-1:0] target;

    assign target    = {redirect_addr_i[XLEN-1:2], 2'b00};  // Word aligned only
    assign fe0_live  = fe0_utd_q & fetch_en_i;
    assign pma_viol  = fe0_live & ~exec_ok_i;
    assign stuck     = ~ahb_rsp_i.hready & fe0_live;
    assign parked    = ~fe1_utd_q & (fe1_inf_q == INF_PARKED);
    assign fe1_pmavn = fe1_utd_q & (fe1_inf_q == INF_PMAVN);

    // Room for every phase in flight plus one new request
    assign inflight  = {1'b0, fe0_utd_q} + {1'b0, fe1_utd_q};
    assign ifb_room  = ifb_free_i > CNT_W'(inflight);

    // Bus request straight from FE0
    assign ahb_req_o.haddr  = fe0_add_q;
    assign ahb_req_o.htrans = (fe0_live & exec_ok_i) ? HTRANS_NONSEQ : HTRANS_IDLE;
    assign fe0_addr_o       = fe0_add_q;

    // FE0 next address, redirect first, then parked target, then increment
    always_comb begin
        fe0_add_d = fe0_add_q;
        fe0_utd_d = fe0_utd_q;
        if (!stuck) begin
            if (redirect_i) begin
                fe0_add_d = target;
                fe0_utd_d = 1'b1;
            end else if (parked) begin
                fe0_add_d = fe1_add_q;
                fe0_utd_d = 1'b1;
            end else if (halt_q | pma_viol) begin
                fe0_utd_d = 1'b0;                           // Wait for a redirect
            end else if (fe0_live) begin
                fe0_add_d = fe0_add_q + XLEN'(4);
                fe0_utd_d = ifb_room;                       // Else re-armed below later
            end else if (!fe0_utd_q) begin
                fe0_utd_d = ifb_room & fetch_en_i;          // Idle, start once room
            end
        end
    end

    // FE1 follows FE0 whenever an address phase completes
    always_comb begin
        fe1_add_d = fe1_add_q;
        fe1_utd_d = fe1_utd_q;
        fe1_inf_d = fe1_inf_q;
        if (redirect_i & stuck) begin
            fe1_add_d = target;                             // FE0 cannot move yet
            fe1_utd_d = 1'b0;
            fe1_inf_d = INF_PARKED;
        end else if (redirect_i | (ahb_rsp_i.hready & parked)) begin
            fe1_utd_d = 1'b0;                               // Old data gets dropped
            fe1_inf_d = INF_NONE;
        end else if (ahb_rsp_i.hready) begin
            fe1_add_d = fe0_add_q;
            fe1_utd_d = fe0_live;
            fe1_inf_d = pma_viol ? INF_PMAVN : INF_NONE;
        end
    end

    always_comb begin
        halt_d = halt_q;
        if (redirect_i | parked)
            halt_d = 1'b0;
        else if (pma_viol & !stuck)
            halt_d = 1'b1;                                  // Fault moves on to FE1
    end

    always_ff @(posedge s_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            fe0_add_q <= '0;                                // First fetch at zero
            fe0_utd_q <= 1'b0;
            fe1_utd_q <= 1'b0;
            fe1_inf_q <= INF_NONE;
            halt_q    <= 1'b0;
        end else begin
            fe0_add_q <= fe0_add_d;
            fe0_utd_q <= fe0_utd_d;
            fe1_utd_q <= fe1_utd_d;
            fe1_inf_q <= fe1_inf_d;
            halt_q    <= halt_d;
        end
    end

    always_ff @(posedge s_clk_i) begin
        fe1_add_q <= fe1_add_d;
    end

    // Entry written when the data phase of FE1 completes
    assign ifb_push_o         = ahb_rsp_i.hready & fe1_utd_q & ~redirect_i;
    assign ifb_wdata_o.instr  = fe1_pmavn ? '0 : ahb_rsp_i.hrdata;
    assign ifb_wdata_o.addr   = fe1_add_q;
    assign ifb_wdata_o.status = fe1_pmavn       ? FETCH_PMAVN :
                                ahb_rsp_i.hresp ? FETCH_BSERR : FETCH_VALID;
    assign flush_o            = redirect_i;

endmodule

//--- hw/fetch_ifb.sv
module fetch_ifb import fetch_pkg::*; #(
    parameter int IFB_DEPTH = 4
) (
    input  logic                           s_clk_i,
    input  logic                           arst_n_i,
    input  logic                           flush_i,         // Drop all entries
    input  logic                           push_i,
    input  ifb_entry_t                     wdata_i,
    input  logic                           pop_stall_i,     // Decode holds the head
    output logic                           valid_o,         // Head entry present
    output ifb_entry_t                     rdata_o,
    output logic [$clog2(IFB_DEPTH+1)-1:0] free_o           // Slots left for throttling
);

    localparam int PTR_W = $clog2(IFB_DEPTH);
    localparam int CNT_W = $clog2(IFB_DEPTH + 1);

    ifb_entry_t       mem_q [IFB_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             do_push;
    logic             do_pop;

    // Wrap at IFB_DEPTH, which need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(IFB_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign valid_o = (count_q != '0);
    assign rdata_o = mem_q[rd_ptr_q];
    assign free_o  = CNT_W'(IFB_DEPTH) - count_q;

    assign do_push = push_i & ~flush_i;                     // Requester keeps room free
    assign do_pop  = valid_o & ~pop_stall_i & ~flush_i;

    always_ff @(posedge s_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push)
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            if (do_pop)
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;        // Both or neither
            endcase
        end
    end

    // Entry storage
    always_ff @(posedge s_clk_i) begin
        if (do_push)
            mem_q[wr_ptr_q] <= wdata_i;
    end

endmodule

//--- hw/fetch_stage_top.sv
module fetch_stage_top import fetch_pkg::*, fetch_cfg_pkg::*; #(
    parameter int IFB_DEPTH   = 4,                  // At least 3
    parameter int PMA_REGIONS = 2
) (
    input  logic            s_clk_i,
    input  logic            arst_n_i,
    input  apb_req_t        apb_req_i,              // Configuration bus
    output apb_rsp_t        apb_rsp_o,
    output ahb_req_t        ahb_req_o,              // Instruction bus
    input  ahb_rsp_t        ahb_rsp_i,
    input  logic            redirect_i,             // From a later stage
    input  logic [XLEN-1:0] redirect_addr_i,
    input  logic            id_stall_i,             // Decode not ready
    output logic            id_valid_o,
    output ifb_entry_t      id_entry_o
);

    localparam int CNT_W = $clog2(IFB_DEPTH + 1);

    logic             fetch_en;
    pma_region_t      regions [PMA_REGIONS];
    logic [XLEN-1:0]  fe0_addr;
    logic             exec_ok;
    logic             ifb_push;
    ifb_entry_t       ifb_wdata;
    logic             flush;
    logic [CNT_W-1:0] ifb_free;

    // Enable and region table
    fetch_cfg_regs #(.PMA_REGIONS(PMA_REGIONS)) i_cfg_regs (
        .s_clk_i    (s_clk_i),
        .arst_n_i   (arst_n_i),
        .apb_req_i  (apb_req_i),
        .apb_rsp_o  (apb_rsp_o),
        .fetch_en_o (fetch_en),
        .regions_o  (regions)
    );

    fetch_pma #(.PMA_REGIONS(PMA_REGIONS)) i_pma (
        .addr_i     (fe0_addr),
        .regions_i  (regions),
        .exec_ok_o  (exec_ok)
    );

    // FE0 and FE1 control
    fetch_addr_phase #(.IFB_DEPTH(IFB_DEPTH)) i_addr_phase (
        .s_clk_i         (s_clk_i),
        .arst_n_i        (arst_n_i),
        .fetch_en_i      (fetch_en),
        .redirect_i      (redirect_i),
        .redirect_addr_i (redirect_addr_i),
        .exec_ok_i       (exec_ok),
        .ifb_free_i      (ifb_free),
        .ahb_rsp_i       (ahb_rsp_i),
        .ahb_req_o       (ahb_req_o),
        .fe0_addr_o      (fe0_addr),
        .ifb_push_o      (ifb_push),
        .ifb_wdata_o     (ifb_wdata),
        .flush_o         (flush)
    );

    // Buffer drained by decode
    fetch_ifb #(.IFB_DEPTH(IFB_DEPTH)) i_ifb (
        .s_clk_i     (s_clk_i),
        .arst_n_i    (arst_n_i),
        .flush_i     (flush),
        .push_i      (ifb_push),
        .wdata_i     (ifb_wdata),
        .pop_stall_i (id_stall_i),
        .valid_o     (id_valid_o),
        .rdata_o     (id_entry_o),
        .free_o      (ifb_free)
    );

endmodule

//--- verification/tb_fetch_stage.sv
module tb_fetch_stage import fetch_pkg::*, fetch_cfg_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int          NREG      = 2;               // PMA regions in the DUT
    localparam int          DEPTH     = 4;               // IFB entries
    localparam logic [31:0] DATA_KEY  = 32'h5a5a_0000;   // Slave data is addr XOR key
    localparam int          STALL_MAX = 40;              // Bus must be idle after this

    logic        s_clk_i;
    logic        arst_n_i;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    ahb_req_t    ahb_req;
    ahb_rsp_t    ahb_rsp;
    logic        redirect;
    logic [31:0] redirect_addr;
    logic        id_stall;
    logic        id_valid;
    ifb_entry_t  id_entry;

    // Commands from the stimulus file
    byte         cmd_q [$];
    logic [31:0] arg0_q [$];
    logic [31:0] arg1_q [$];
    logic [31:0] arg2_q [$];
    int          total_exp;
    bit          loaded;

    // Register mirror for the expected PMA result
    logic [31:0] mir_base [NREG];
    logic [31:0] mir_mask [NREG];
    logic        mir_exec [NREG];

    // Slave model and scoreboard state
    int          wait_pct;
    bit          force_wait;                              // Hold hready low while pending
    logic [31:0] err_addr;
    bit          pend;                                    // Data phase outstanding
    logic [31:0] pend_addr;
    logic [31:0] exp_addr;
    int          seg_count;                               // Entries since last redirect
    bit          halted;
    int          stall_run;
    int          entry_errs;
    int          apb_errs;
    int          bus_errs;

    fetch_stage_top #(.IFB_DEPTH(DEPTH), .PMA_REGIONS(NREG)) i_dut (
        .s_clk_i         (s_clk_i),
        .arst_n_i        (arst_n_i),
        .apb_req_i       (apb_req),
        .apb_rsp_o       (apb_rsp),
        .ahb_req_o       (ahb_req),
        .ahb_rsp_i       (ahb_rsp),
        .redirect_i      (redirect),
        .redirect_addr_i (redirect_addr),
        .id_stall_i      (id_stall),
        .id_valid_o      (id_valid),
        .id_entry_o      (id_entry)
    );

    initial begin
        s_clk_i = 1'b0;
        forever #4 s_clk_i = ~s_clk_i;                    // 8 ns period
    end

    function automatic bit pma_ok(input logic [31:0] addr);
        for (int k = 0; k < NREG; k++) begin
            if (mir_exec[k] && ((addr & mir_mask[k]) == mir_base[k]))
                return 1'b1;
        end
        return 1'b0;
    endfunction

    task automatic check_entry(input ifb_entry_t got, input ifb_entry_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED @%0t: entry exp addr %h instr %h status %0d, got %h %h %0d",
                     $time, exp.addr, exp.instr, exp.status, got.addr, got.instr, got.status);
            entry_errs++;
        end
    endtask

    // Data compared only for reads, write data on prdata is not specified
    task automatic check_apb(input apb_rsp_t got, input apb_rsp_t exp, input bit with_data);
        if (got.pslverr !== exp.pslverr || got.pready !== exp.pready ||
            (with_data && got.prdata !== exp.prdata)) begin
            $display("CHECK FAILED @%0t: apb exp data %h err %b, got data %h err %b",
                     $time, exp.prdata, exp.pslverr, got.prdata, got.pslverr);
            apb_errs++;
        end
    endtask

    task automatic apb_access(input bit wr, input logic [11:0] off, input logic [31:0] data,
                              input bit exp_err);
        apb_rsp_t exp;
        @(posedge s_clk_i);
        apb_req.psel    <= 1'b1;                          // Setup phase
        apb_req.pwrite  <= wr;
        apb_req.paddr   <= off;
        apb_req.pwdata  <= wr ? data : '0;
        @(posedge s_clk_i);
        apb_req.penable <= 1'b1;
        @(posedge s_clk_i);
        exp.prdata  = exp_err ? '0 : data;
        exp.pready  = 1'b1;
        exp.pslverr = exp_err;
        check_apb(apb_rsp, exp, !wr);
        apb_req.psel    <= 1'b0;
        apb_req.penable <= 1'b0;
        if (wr && !exp_err) begin                         // Mirror follows the map
            for (int k = 0; k < NREG; k++) begin
                if (off == REG_ATTR)
                    mir_exec[k] = data[k];
                if (off == REG_BASE0 + 12'(8 * k))
                    mir_base[k] = data;
                if (off == REG_MASK0 + 12'(8 * k))
                    mir_mask[k] = data;
            end
        end
    endtask

    task automatic do_redirect(input logic [31:0] target);
        @(posedge s_clk_i);
        redirect      <= 1'b1;
        redirect_addr <= target;
        @(posedge s_clk_i);
        redirect      <= 1'b0;
    endtask

    // Redirect while an address phase is held by a wait state
    task automatic redirect_in_wait(input logic [31:0] target);
        force_wait <= 1'b1;
        do @(posedge s_clk_i);
        while (!(ahb_req.htrans == HTRANS_NONSEQ && !ahb_rsp.hready));
        redirect      <= 1'b1;
        redirect_addr <= target;
        @(posedge s_clk_i);
        redirect      <= 1'b0;
        force_wait    <= 1'b0;
    endtask

    task automatic stall_window(input int start, input int len);
        repeat (start) @(posedge s_clk_i);
        if (len > 0) begin
            id_stall <= 1'b1;
            repeat (len) @(posedge s_clk_i);
            id_stall <= 1'b0;
        end
    endtask

    task automatic load_stim();
        int  fd;
        int  rc;
        byte c;
        logic [31:0] a0, a1, a2;
        logic [8*160-1:0] skip;
        fd = $fopen("verification/fetch_stim.txt", "r");
        if (fd == 0) begin
            $display("Stimulus file verification/fetch_stim.txt could not be opened");
            return;
        end
        forever begin
            rc = $fscanf(fd, " %c", c);
            if (rc != 1)
                break;
            a0 = '0;
            a1 = '0;
            a2 = '0;
            case (c)
                "#":      rc = $fgets(skip, fd);          // Comment line
                "W", "R": rc = $fscanf(fd, "%h %h %h", a0, a1, a2);
                "S":      rc = $fscanf(fd, "%h %h", a0, a1);
                default:  rc = $fscanf(fd, "%h", a0);
            endcase
            if (c != "#") begin
                cmd_q.push_back(c);
                arg0_q.push_back(a0);
                arg1_q.push_back(a1);
                arg2_q.push_back(a2);
                if (c == "E")
                    total_exp += a0;
            end
        end
        $fclose(fd);
        loaded = 1'b1;
    endtask

    // AHB slave, waits only while a data phase is outstanding
    always @(posedge s_clk_i) begin
        if (arst_n_i) begin
            if (ahb_rsp.hready) begin
                pend      = (ahb_req.htrans == HTRANS_NONSEQ);
                pend_addr = ahb_req.haddr;
            end
            if (pend) begin
                ahb_rsp.hready <= !(force_wait || ($urandom % 100) < wait_pct);
                ahb_rsp.hrdata <= pend_addr ^ DATA_KEY;
                ahb_rsp.hresp  <= (pend_addr == err_addr);
            end else begin
                ahb_rsp.hready <= 1'b1;
                ahb_rsp.hresp  <= 1'b0;
            end
        end
    end

    // Decode sink with scoreboard
    always @(posedge s_clk_i) begin
        ifb_entry_t exp;
        if (arst_n_i) begin
            if (redirect) begin
                exp_addr  = redirect_addr;                // IFB flushed, stream restarts
                seg_count <= 0;
                halted    = 1'b0;
            end else if (id_valid && !id_stall) begin
                if (halted) begin
                    $display("Entry at %h arrived after a PMA fault at %0t",
                             id_entry.addr, $time);
                    entry_errs++;
                end
                exp.addr   = exp_addr;
                exp.instr  = exp_addr ^ DATA_KEY;
                exp.status = FETCH_VALID;
                if (!pma_ok(exp_addr)) begin
                    exp.status = FETCH_PMAVN;
                    exp.instr  = '0;
                end else if (exp_addr == err_addr) begin
                    exp.status = FETCH_BSERR;
                end
                check_entry(id_entry, exp);
                halted   = (exp.status == FETCH_PMAVN);
                exp_addr = exp_addr + 32'd4;
                seg_count <= seg_count + 1;
            end
        end
    end

    // Bus monitor
    always @(posedge s_clk_i) begin
        if (arst_n_i) begin
            stall_run = id_stall ? stall_run + 1 : 0;
            if (ahb_req.htrans == HTRANS_NONSEQ && !pma_ok(ahb_req.haddr)) begin
                $display("Transfer issued to non-executable %h at %0t", ahb_req.haddr, $time);
                bus_errs++;
            end
            if (ahb_req.htrans == HTRANS_NONSEQ && stall_run > STALL_MAX) begin
                $display("Bus still busy with decode stalled at %0t", $time);
                bus_errs++;
            end
        end
    end

    initial begin
        wait (loaded);
        repeat (200 * total_exp + 3000) @(posedge s_clk_i);
        $display("Watchdog expired after %0d cycles, run stopped", 200 * total_exp + 3000);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        void'($urandom(32'hcad860bb));
        arst_n_i       = 1'b0;
        apb_req        = '0;
        ahb_rsp.hrdata = '0;
        ahb_rsp.hready = 1'b1;
        ahb_rsp.hresp  = 1'b0;
        redirect       = 1'b0;
        redirect_addr  = '0;
        id_stall       = 1'b0;
        err_addr       = 32'hffff_ffff;                   // Unaligned, never hit
        exp_addr       = '0;                              // Fetch starts at zero
        for (int k = 0; k < NREG; k++) begin
            mir_base[k] = '0;
            mir_mask[k] = '0;
            mir_exec[k] = 1'b0;
        end
        load_stim();
        repeat (2) @(posedge s_clk_i);
        arst_n_i <= 1'b1;
        for (int i = 0; i < cmd_q.size(); i++) begin
            case (cmd_q[i])
                "W": apb_access(1'b1, arg0_q[i][11:0], arg1_q[i], arg2_q[i][0]);
                "R": apb_access(1'b0, arg0_q[i][11:0], arg1_q[i], arg2_q[i][0]);
                "J": do_redirect(arg0_q[i]);
                "K": redirect_in_wait(arg0_q[i]);
                "S": stall_window(arg0_q[i], arg1_q[i]);
                "P": wait_pct <= arg0_q[i];
                "B": err_addr <= arg0_q[i];
                "E": begin
                    do
                        @(posedge s_clk_i);
                    while (seg_count < arg0_q[i]);
                end
                default: begin
                    $display("Unknown stimulus command %c", cmd_q[i]);
                    apb_errs++;
                end
            endcase
        end
        repeat (5) @(posedge s_clk_i);
        $display("Errors: entry %0d, apb %0d, bus %0d, commands %0d",
                 entry_errs, apb_errs, bus_errs, cmd_q.size());
        if (loaded && entry_errs + apb_errs + bus_errs == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

//--- verification/fetch_stim.txt
# All values hex. W/R offset data err, J/K target (K during wait), S start len
# P wait percent, B bus error address, E entries since last redirect
R 000 00000000 0
W 010 00001000 0
W 014 FFFFF000 0
W 018 00002000 0
W 01C FFFFFF00 0
W 004 00000003 0
R 010 00001000 0
R 014 FFFFF000 0
R 018 00002000 0
R 01C FFFFFF00 0
R 004 00000003 0
W 020 12345678 1
R 020 00000000 1
W 000 00000001 0
R 000 00000001 0
E 1
S 14 0
J 00001000
E A
P 28
J 00001100
E A
S 0 3C
E 28
B 00001040
J 00001000
E 14
K 00001800
E A
P 0
J 000020F0
E 5
S 14 0

//--- vlog.f
hw/fetch_pkg.sv
hw/fetch_cfg_pkg.sv
hw/fetch_cfg_regs.sv
hw/fetch_pma.sv
hw/fetch_addr_phase.sv
hw/fetch_ifb.sv
hw/fetch_stage_top.sv
verification/tb_fetch_stage.sv
